//--- Bender.yml
package:
  name: video_adjust

sources:
  - files:
      - rtl/video_pkg.sv
      - rtl/adjust_pkg.sv
      - rtl/adjust_ctrl.sv
      - rtl/channel_adjust.sv
      - rtl/clip_stats.sv
      - rtl/video_adjust_top.sv
  - target: test
    files:
      - tb/video_adjust_sva.sv
      - tb/video_adjust_tb.sv

//--- build.f
rtl/video_pkg.sv
rtl/adjust_pkg.sv
rtl/adjust_ctrl.sv
rtl/channel_adjust.sv
rtl/clip_stats.sv
rtl/video_adjust_top.sv
tb/video_adjust_sva.sv
tb/video_adjust_tb.sv

//--- rtl/adjust_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module adjust_ctrl #(
    parameter int COE_WIDTH = 16
) (
    input  wire                                 clk,
    input  wire                                 rst_n_i,

    // configuration write port
    input  wire                                 wr_i,
    input  wire                                 addr_i,
    input  wire [adjust_pkg::CFG_WIDTH-1:0]     wdata_i,

    // input video strobes
    input  wire                                 vs_i,
    input  wire                                 de_i,
    input  wire                                 hs_i,

    // active coefficients for the datapath
    output logic [COE_WIDTH-1:0]                contrast_o,
    output logic signed [COE_WIDTH-1:0]         brightness_o,

    // strobes delayed to match the datapath
    output logic                                de_o,
    output logic                                hs_o,
    output logic                                vs_o
);

    localparam int LAT = video_pkg::LATENCY;

    adjust_pkg::cfg_word_u       wr_word;
    logic [COE_WIDTH-1:0]        contrast_sh;
    logic signed [COE_WIDTH-1:0] brightness_sh;
    logic [LAT-1:0]              de_sr;
    logic [LAT-1:0]              hs_sr;
    logic [LAT-1:0]              vs_sr;
    logic                        frame_start;

    assign wr_word = wdata_i;

    // ------------------------------------------------------------
    // shadow registers, written any time
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            contrast_sh   <= COE_WIDTH'(adjust_pkg::CONTRAST_RST);
            brightness_sh <= COE_WIDTH'(adjust_pkg::BRIGHTNESS_RST);
        end else if (wr_i) begin
            // address picks which view of the word is meaningful
            case (addr_i)
                adjust_pkg::ADDR_CONTRAST:
                    contrast_sh <= COE_WIDTH'(wr_word.contrast);
                adjust_pkg::ADDR_BRIGHTNESS:
                    brightness_sh <= COE_WIDTH'(wr_word.brightness);
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------
    // active registers, updated at frame start only
    // ------------------------------------------------------------

    // vs_sr[0] is vs_i from the previous edge
    assign frame_start = vs_i & ~vs_sr[0];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            contrast_o   <= COE_WIDTH'(adjust_pkg::CONTRAST_RST);
            brightness_o <= COE_WIDTH'(adjust_pkg::BRIGHTNESS_RST);
        end else if (frame_start) begin
            contrast_o   <= contrast_sh;
            brightness_o <= brightness_sh;
        end
    end

    // ------------------------------------------------------------
    // sync delay line
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            de_sr <= '0;
            hs_sr <= '0;
            vs_sr <= '0;
        end else begin
            de_sr <= {de_sr[LAT-2:0], de_i};
            hs_sr <= {hs_sr[LAT-2:0], hs_i};
            vs_sr <= {vs_sr[LAT-2:0], vs_i};
        end
    end

    assign de_o = de_sr[LAT-1];
    assign hs_o = hs_sr[LAT-1];
    assign vs_o = vs_sr[LAT-1];

endmodule

`default_nettype wire

//--- rtl/adjust_pkg.sv
`default_nettype none

package adjust_pkg;

    // configuration word width on the write port
    parameter int CFG_WIDTH = 16;

    // ------------------------------------------------------------
    // register map
    // ------------------------------------------------------------

    parameter logic ADDR_CONTRAST   = 1'b0;
    parameter logic ADDR_BRIGHTNESS = 1'b1;

    // ------------------------------------------------------------
    // reset values
    // ------------------------------------------------------------

    // unity gain
    parameter logic [CFG_WIDTH-1:0] CONTRAST_RST = 16'd64;

    // no offset
    parameter logic signed [CFG_WIDTH-1:0] BRIGHTNESS_RST = 16'sd0;

    // ------------------------------------------------------------
    // configuration write word
    // ------------------------------------------------------------

    // same 16 bits, read unsigned for contrast or signed for brightness
    typedef union packed {
        logic [CFG_WIDTH-1:0]        contrast;
        logic signed [CFG_WIDTH-1:0] brightness;
    } cfg_word_u;

endpackage

`default_nettype wire

//--- rtl/channel_adjust.sv
`timescale 1ns/10ps
`default_nettype none

module channel_adjust #(
    parameter int PIXEL_WIDTH        = 8,
    parameter int COE_WIDTH          = 16,
    parameter int COE_FRACTION_WIDTH = 6
) (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire [PIXEL_WIDTH-1:0]        pixel_i,
    input  wire [COE_WIDTH-1:0]          contrast_i,
    input  wire signed [COE_WIDTH-1:0]   brightness_i,
    output logic [PIXEL_WIDTH-1:0]       pixel_o,
    output logic                         clip_o
);

    // register stages below, must agree with the sync delay line
    localparam int STAGES = 5;

    localparam int PROD_W = COE_WIDTH + PIXEL_WIDTH;
    localparam int OFFS_W = COE_WIDTH + COE_FRACTION_WIDTH + 1;
    localparam int SUM_W  = COE_WIDTH + PIXEL_WIDTH + COE_FRACTION_WIDTH + 2;

    // mid grey, the pivot for contrast
    localparam int HALF_SCALE = 1 << (PIXEL_WIDTH - 1);

    // one half in the fraction, for round to nearest
    localparam logic signed [SUM_W-1:0] ROUND_ADD = SUM_W'(1) << (COE_FRACTION_WIDTH - 1);

    if (STAGES != video_pkg::LATENCY) begin : g_latency_check
        $error("channel_adjust depth differs from video_pkg::LATENCY");
    end

    logic [PROD_W-1:0]        prod_q;
    logic [PROD_W-1:0]        mid_q;
    logic signed [OFFS_W-1:0] offs_q;
    logic signed [SUM_W-1:0]  diff_q;
    logic signed [OFFS_W-1:0] offs_d_q;
    logic signed [SUM_W-1:0]  sum_q;
    logic signed [SUM_W-1:0]  rnd_q;

    // ------------------------------------------------------------
    // stages 1 to 4, arithmetic
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        // stage 1: products and the scaled offset
        prod_q <= contrast_i * pixel_i;
        mid_q  <= contrast_i * PROD_W'(HALF_SCALE);
        offs_q <= (OFFS_W'(brightness_i) + OFFS_W'(HALF_SCALE)) <<< COE_FRACTION_WIDTH;

        // stage 2: contrast * (p - 128)
        diff_q   <= $signed(SUM_W'(prod_q)) - $signed(SUM_W'(mid_q));
        offs_d_q <= offs_q;

        // stage 3
        sum_q <= diff_q + SUM_W'(offs_d_q);

        // stage 4
        rnd_q <= sum_q + ROUND_ADD;
    end

    // ------------------------------------------------------------
    // stage 5, clamp and clip flag
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pixel_o <= '0;
            clip_o  <= 1'b0;
        end else if (rnd_q[SUM_W-1]) begin
            // below zero
            pixel_o <= '0;
            clip_o  <= 1'b1;
        end else if (|rnd_q[SUM_W-2:COE_FRACTION_WIDTH+PIXEL_WIDTH]) begin
            // above full scale
            pixel_o <= '1;
            clip_o  <= 1'b1;
        end else begin
            pixel_o <= rnd_q[COE_FRACTION_WIDTH +: PIXEL_WIDTH];
            clip_o  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/clip_stats.sv
`timescale 1ns/10ps
`default_nettype none

module clip_stats #(
    parameter int PIXEL_WIDTH = 8
) (
    input  wire                              clk,
    input  wire                              rst_n_i,
    input  wire [video_pkg::NUM_COMP-1:0]    clip_i,
    input  wire                              de_i,
    input  wire                              vs_i,
    output logic [PIXEL_WIDTH*3-1:0]         clip_count_o,
    output logic                             frame_done_o
);

    // wide enough for every component of a large frame
    localparam int CNT_W = PIXEL_WIDTH * 3;
    localparam int INC_W = $clog2(video_pkg::NUM_COMP + 1);

    logic [CNT_W-1:0] cnt_q;
    logic [INC_W-1:0] inc;
    logic [CNT_W:0]   cnt_next;
    logic [CNT_W-1:0] cnt_sat;
    logic             vs_q;
    logic             vs_rise;

    // number of clipped components on this cycle
    always_comb begin
        inc = '0;
        for (int i = 0; i < video_pkg::NUM_COMP; i++) begin
            inc = inc + INC_W'(clip_i[i]);
        end
    end

    assign cnt_next = {1'b0, cnt_q} + (CNT_W + 1)'(inc);
    assign cnt_sat  = cnt_next[CNT_W] ? '1 : cnt_next[CNT_W-1:0];
    assign vs_rise  = vs_i & ~vs_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vs_q         <= 1'b0;
            cnt_q        <= '0;
            clip_count_o <= '0;
            frame_done_o <= 1'b0;
        end else begin
            vs_q         <= vs_i;
            frame_done_o <= vs_rise;
            if (vs_rise) begin
                // report the finished frame, start over
                clip_count_o <= cnt_q;
                cnt_q        <= '0;
            end else if (de_i) begin
                cnt_q <= cnt_sat;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/video_adjust_top.sv
`timescale 1ns/10ps
`default_nettype none

module video_adjust_top #(
    parameter int PIXEL_WIDTH        = video_pkg::PIXEL_WIDTH_DEF,
    parameter int COE_WIDTH          = video_pkg::COE_WIDTH_DEF,
    parameter int COE_FRACTION_WIDTH = video_pkg::COE_FRACTION_WIDTH_DEF
) (
    input  wire                                          clk,
    input  wire                                          rst_n_i,

    // configuration writes
    input  wire                                          wr_i,
    input  wire                                          addr_i,
    input  wire [adjust_pkg::CFG_WIDTH-1:0]              wdata_i,

    // video in, red in the low slice
    input  wire [PIXEL_WIDTH*video_pkg::NUM_COMP-1:0]    rgb_i,
    input  wire                                          de_i,
    input  wire                                          hs_i,
    input  wire                                          vs_i,

    // video out
    output logic [PIXEL_WIDTH*video_pkg::NUM_COMP-1:0]   rgb_o,
    output logic                                         de_o,
    output logic                                         hs_o,
    output logic                                         vs_o,

    // per-frame statistics
    output logic [PIXEL_WIDTH*3-1:0]                     clip_count_o,
    output logic                                         frame_done_o
);

    logic [COE_WIDTH-1:0]              contrast;
    logic signed [COE_WIDTH-1:0]       brightness;
    logic [video_pkg::NUM_COMP-1:0]    clip;

    adjust_ctrl #(
        .COE_WIDTH (COE_WIDTH)
    ) u_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .wr_i         (wr_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .vs_i         (vs_i),
        .de_i         (de_i),
        .hs_i         (hs_i),
        .contrast_o   (contrast),
        .brightness_o (brightness),
        .de_o         (de_o),
        .hs_o         (hs_o),
        .vs_o         (vs_o)
    );

    // one datapath per colour component
    for (genvar k = 0; k < video_pkg::NUM_COMP; k++) begin : g_ch
        channel_adjust #(
            .PIXEL_WIDTH        (PIXEL_WIDTH),
            .COE_WIDTH          (COE_WIDTH),
            .COE_FRACTION_WIDTH (COE_FRACTION_WIDTH)
        ) u_ch (
            .clk          (clk),
            .rst_n_i      (rst_n_i),
            .pixel_i      (rgb_i[PIXEL_WIDTH*k +: PIXEL_WIDTH]),
            .contrast_i   (contrast),
            .brightness_i (brightness),
            .pixel_o      (rgb_o[PIXEL_WIDTH*k +: PIXEL_WIDTH]),
            .clip_o       (clip[k])
        );
    end

    // counts against the delayed strobes, aligned with the clip flags
    clip_stats #(
        .PIXEL_WIDTH (PIXEL_WIDTH)
    ) u_stats (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .clip_i       (clip),
        .de_i         (de_o),
        .vs_i         (vs_o),
        .clip_count_o (clip_count_o),
        .frame_done_o (frame_done_o)
    );

endmodule

`default_nettype wire

//--- rtl/video_pkg.sv
`default_nettype none

package video_pkg;

    // ------------------------------------------------------------
    // pixel format
    // ------------------------------------------------------------

    // bits per colour component
    parameter int PIXEL_WIDTH_DEF = 8;

    // components per pixel, red in the low slice and blue in the high one
    parameter int NUM_COMP = 3;

    // ------------------------------------------------------------
    // coefficient format
    // ------------------------------------------------------------

    // contrast and brightness word width
    parameter int COE_WIDTH_DEF = 16;

    // contrast fraction bits, 64 is 1.0
    parameter int COE_FRACTION_WIDTH_DEF = 6;

    // ------------------------------------------------------------
    // pipeline timing
    // ------------------------------------------------------------

    // pixel in to adjusted pixel out, sync strobes follow the same delay
    parameter int LATENCY = 5;

endpackage

`default_nettype wire

//--- tb/video_adjust_golden.txt
// kind a b c in hex, rgb words are blue:green:red
// 0 write (a addr, b data)  1 pixel (a vs:hs:de, b rgb_i, c rgb_o)  2 clip count  3 gap  f end
// frame A, reset values, output follows input
1 4 000000 000000
2 0 0 0
1 1 123456 123456
1 1 00FF7F 00FF7F
// contrast 2.0, held in shadow
0 0 0080 0
1 1 FF0080 FF0080
3 0 0 0
// brightness -40
0 1 FFD8 0
1 1 A5C30F A5C30F
1 1 FFFFFF FFFFFF
// frame B, out = 2p - 168 clamped
1 4 000000 000000
2 0 0 0
1 1 F08010 FF5800
1 1 A0D354 98FE00
1 1 6453D4 2000FF
// outside de, clips but not counted
1 0 FF0000 FF0000
3 0 0 0
1 1 209070 007838
// contrast 1.25 and brightness 10 mid frame
0 0 0050 0
0 1 000A 0
1 1 8000FF 5800FF
// frame C, new values from here
1 4 000000 000000
2 7 0 0
1 1 7E8180 888B8A
1 1 0AFF00 00FF00
1 1 DAE017 FBFF07
1 1 DE1112 FF0001
3 0 0 0
1 0 00FF00 00FF00
1 1 6040DD 623AFE
// closing vs reports frame C
1 4 000000 000000
2 6 0 0
f 0 0 0

//--- tb/video_adjust_sva.sv
`timescale 1ns/10ps
`default_nettype none

module video_adjust_sva #(
    parameter int PIXEL_WIDTH = 8
) (
    input wire                                        clk,
    input wire                                        rst_n_i,
    input wire                                        de_i,
    input wire                                        hs_i,
    input wire                                        vs_i,
    input wire [PIXEL_WIDTH*video_pkg::NUM_COMP-1:0]  rgb_o,
    input wire                                        de_o,
    input wire                                        hs_o,
    input wire                                        vs_o,
    input wire [PIXEL_WIDTH*3-1:0]                    clip_count_o,
    input wire                                        frame_done_o
);

    // number of assertion failures so far
    int fail_count = 0;

    // ------------------------------------------------------------
    // sync strobes follow the pixel pipeline
    // ------------------------------------------------------------

    a_de_delay: assert property (@(posedge clk) disable iff (!rst_n_i)
        de_o == $past(de_i, video_pkg::LATENCY))
        else begin
            $error("de_o is not de_i delayed by the pipeline latency");
            fail_count++;
        end

    a_hs_delay: assert property (@(posedge clk) disable iff (!rst_n_i)
        hs_o == $past(hs_i, video_pkg::LATENCY))
        else begin
            $error("hs_o is not hs_i delayed by the pipeline latency");
            fail_count++;
        end

    a_vs_delay: assert property (@(posedge clk) disable iff (!rst_n_i)
        vs_o == $past(vs_i, video_pkg::LATENCY))
        else begin
            $error("vs_o is not vs_i delayed by the pipeline latency");
            fail_count++;
        end

    // one cycle right after each rise of vs_o
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        frame_done_o == ($past(vs_o) && !$past(vs_o, 2)))
        else begin
            $error("frame_done_o is not a single pulse after vs_o rises");
            fail_count++;
        end

    // ------------------------------------------------------------
    // quiet outputs in reset
    // ------------------------------------------------------------

    a_reset_quiet: assert property (@(posedge clk)
        (!rst_n_i ##1 !rst_n_i) |-> (rgb_o == '0 && !de_o && !hs_o && !vs_o
                                     && clip_count_o == '0 && !frame_done_o))
        else begin
            $error("outputs not cleared while reset is held");
            fail_count++;
        end

endmodule

bind video_adjust_top video_adjust_sva #(.PIXEL_WIDTH(PIXEL_WIDTH)) u_sva (.*);

`default_nettype wire

//--- tb/video_adjust_tb.sv
`timescale 1ns/10ps
`default_nettype none

module video_adjust_tb;

    localparam int PW           = video_pkg::PIXEL_WIDTH_DEF;
    localparam int RGB_W        = PW * video_pkg::NUM_COMP;
    localparam int CNT_W        = PW * 3;
    localparam int LAT          = video_pkg::LATENCY;
    localparam int GOLDEN_WORDS = 256;
    localparam int DONE_TIMEOUT = 32;

    logic                             clk;
    logic                             rst_n_i;
    logic                             wr_i;
    logic                             addr_i;
    logic [adjust_pkg::CFG_WIDTH-1:0] wdata_i;
    logic [RGB_W-1:0]                 rgb_i;
    logic                             de_i;
    logic                             hs_i;
    logic                             vs_i;
    logic [RGB_W-1:0]                 rgb_o;
    logic                             de_o;
    logic                             hs_o;
    logic                             vs_o;
    logic [CNT_W-1:0]                 clip_count_o;
    logic                             frame_done_o;

    // four words per record with the kind first
    logic [31:0]      golden_mem [GOLDEN_WORDS];
    // {check rgb, vs, hs, de, rgb} for every driven cycle
    logic [RGB_W+3:0] exp_q [$];
    logic [31:0]      lcg_state;
    logic             done_seen;
    logic [CNT_W-1:0] done_count;
    int               checks;

    video_adjust_top DUT (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ------------------------------------------------------------
    // failure reporting and compare tasks
    // ------------------------------------------------------------

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_rgb(input logic [RGB_W-1:0] got, input logic [RGB_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            report_error($sformatf("rgb_o is %06h, expected %06h", got, exp));
        end
    endtask

    task automatic check_sync(input logic [2:0] got, input logic [2:0] exp);
        checks++;
        if (got !== exp) begin
            report_error($sformatf("{vs_o,hs_o,de_o} is %03b, expected %03b", got, exp));
        end
    endtask

    task automatic check_clip_count(input logic [CNT_W-1:0] got, input logic [CNT_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            report_error($sformatf("clip_count_o is %0d, expected %0d", got, exp));
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // ------------------------------------------------------------
    // stimulus driven on the falling edge with one cycle per call
    // ------------------------------------------------------------

    task automatic step(input logic [2:0] flags, input logic [RGB_W-1:0] pix,
                        input logic [RGB_W-1:0] exp_pix, input logic chk);
        logic [RGB_W+3:0] oldest;
        @(negedge clk);
        if (DUT.u_sva.fail_count != 0) begin
            $display("a bound assertion on the DUT ports failed before %0t ns", $time);
            abort_run();
        end
        if (frame_done_o) begin
            done_seen  = 1'b1;
            done_count = clip_count_o;
        end
        // entry pushed LAT cycles ago is at the outputs now
        if (exp_q.size() == LAT) begin
            oldest = exp_q.pop_front();
            check_sync({vs_o, hs_o, de_o}, oldest[RGB_W+2:RGB_W]);
            if (oldest[RGB_W+3]) begin
                check_rgb(rgb_o, oldest[RGB_W-1:0]);
            end
        end
        {vs_i, hs_i, de_i} = flags;
        rgb_i = pix;
        wr_i  = 1'b0;
        exp_q.push_back({chk, flags, exp_pix});
    endtask

    task automatic write_reg(input logic addr, input logic [15:0] data);
        adjust_pkg::cfg_word_u word;
        if (addr == adjust_pkg::ADDR_CONTRAST) begin
            word.contrast = data;
        end else begin
            word.brightness = $signed(data);
        end
        step(3'b000, '0, '0, 1'b0);
        wr_i    = 1'b1;
        addr_i  = addr;
        wdata_i = word;
    endtask

    // hs blanking with random pixels that must never count
    task automatic line_gap();
        int gap;
        lcg_state = lcg_next(lcg_state);
        gap = 1 + int'(lcg_state[20:16]) % 6;
        for (int i = 0; i < gap; i++) begin
            lcg_state = lcg_next(lcg_state);
            step(3'b010, lcg_state[31:8], '0, 1'b0);
        end
    endtask

    task automatic wait_frame_done(input logic [CNT_W-1:0] exp_count);
        int n;
        n = 0;
        while (!done_seen && n < DONE_TIMEOUT) begin
            step(3'b000, '0, '0, 1'b0);
            n++;
        end
        if (!done_seen) begin
            $display("timeout: frame_done_o never pulsed within %0d cycles", DONE_TIMEOUT);
            abort_run();
        end else begin
            check_clip_count(done_count, exp_count);
            done_seen = 1'b0;
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------

    initial begin
        int idx;
        rst_n_i    = 1'b0;
        wr_i       = 1'b0;
        addr_i     = 1'b0;
        wdata_i    = '0;
        rgb_i      = '0;
        de_i       = 1'b0;
        hs_i       = 1'b0;
        vs_i       = 1'b0;
        lcg_state  = 32'h95b6de72;
        done_seen  = 1'b0;
        done_count = '0;
        checks     = 0;
        $readmemh("tb/video_adjust_golden.txt", golden_mem);

        repeat (16) @(negedge clk);
        check_rgb(rgb_o, '0);
        check_sync({vs_o, hs_o, de_o}, 3'b000);
        check_clip_count(clip_count_o, '0);
        rst_n_i = 1'b1;

        idx = 0;
        while (idx <= GOLDEN_WORDS - 4 && golden_mem[idx] != 32'hf) begin
            case (golden_mem[idx])
                32'h0: write_reg(golden_mem[idx+1][0], golden_mem[idx+2][15:0]);
                32'h1: step(golden_mem[idx+1][2:0], golden_mem[idx+2][RGB_W-1:0],
                            golden_mem[idx+3][RGB_W-1:0], 1'b1);
                32'h2: wait_frame_done(golden_mem[idx+1][CNT_W-1:0]);
                32'h3: line_gap();
                default: begin
                    $display("unknown record kind %0h at word %0d", golden_mem[idx], idx);
                    abort_run();
                end
            endcase
            idx += 4;
        end

        // flush the pipeline
        repeat (LAT) step(3'b000, '0, '0, 1'b0);

        if (checks <= 3) begin
            $display("no vectors were applied, golden file missing or empty");
            abort_run();
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
